//--- bench/movegen_golden.txt
# test <name> <white to move 1/0> <count> then count pairs of <square 0..63> <piece hex>
# then the expected 20-bit move words in hex, one per line, and end closes the test
test no_white_pieces 1 2 60 1 48 6
end
test knight_a1 1 1 0 d
28011
2800a
end
test pawn_blocked_captures 1 4 28 e 36 4 35 5 37 3
3475c
346ec
end
test mixed_white 1 8 4 9 1 d 7 d 8 e 11 e 16 6 60 1 20 5
3321a
33362
2f029
2f032
29182
29012
end
test black_pawns 0 7 63 1 52 6 43 d 25 6 17 e 16 b 4 9
34d5d
34c25
316c2
end

//--- compile.f
design/movegen_pkg.sv
design/board_squares.sv
design/piece_stacks.sv
design/move_targets.sv
design/target_arbiter.sv
design/move_emitter.sv
design/movegen_top.sv
bench/movegen_checker.sv
bench/tb_movegen.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_movegen -f compile.f
	./obj_dir/Vtb_movegen | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_movegen.sv
`timescale 1ns/1ps

module tb_movegen;

  import movegen_pkg::*;

  localparam int MAX_TESTS    = 16;
  localparam int RESET_CYCLES = 8;
  // load, then the worst case of sixteen pieces that each walk the whole mask
  localparam int CYCLES_PER_TEST = NUM_SQUARES + STACK_DEPTH * 66 + 20;

  logic      clk;
  logic      i_arst_n;
  logic      i_pos_valid;
  piece_t    i_pos_data;
  logic      i_pos_sop;
  logic      i_wtp;
  logic      i_start;
  logic      o_uci_valid;
  uci_move_t o_uci_data;
  logic      o_uci_sop;
  logic      o_uci_eop;

  piece_t positions [MAX_TESTS][NUM_SQUARES];
  logic   side_wtp  [MAX_TESTS];
  int     num_tests    = 0;
  int     cycle_count  = 0;
  int     cycle_limit  = 0;
  int     seed         = 32'h9345_87bd;
  int     tests_done;
  int     tests_failed;
  int     error_count;

  movegen_top movegen_top_inst (
    .clk(clk), .i_arst_n(i_arst_n), .i_pos_valid(i_pos_valid), .i_pos_data(i_pos_data),
    .i_pos_sop(i_pos_sop), .i_wtp(i_wtp), .i_start(i_start), .o_uci_valid(o_uci_valid),
    .o_uci_data(o_uci_data), .o_uci_sop(o_uci_sop), .o_uci_eop(o_uci_eop)
  );

  movegen_checker movegen_checker_inst (
    .clk(clk), .i_arst_n(i_arst_n), .i_uci_valid(o_uci_valid), .i_uci_data(o_uci_data),
    .i_uci_sop(o_uci_sop), .i_uci_eop(o_uci_eop), .o_tests_done(tests_done),
    .o_tests_failed(tests_failed), .o_error_count(error_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // the DUT has no back-pressure, so a stuck list only shows up as a missing eop
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT never closed its move list", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // only the positions are kept here, move words and end marks are skipped
  task automatic read_positions(output bit ok);
    int            fd;
    int            code;
    int            nsq;
    int            sq;
    int            pc;
    int            wtp;
    string         tok;
    string         name;
    logic [1023:0] skip_line;
    piece_t        board [NUM_SQUARES];
    ok = 1'b0;
    fd = $fopen("bench/movegen_golden.txt", "r");
    if (fd != 0) begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          code = $fgets(skip_line, fd);
        end else if (tok == "test") begin
          code = $fscanf(fd, "%s %d %d", name, wtp, nsq);
          // every square not listed is empty
          for (int s = 0; s < NUM_SQUARES; s++) begin
            board[s] = '0;
          end
          for (int k = 0; k < nsq; k++) begin
            code = $fscanf(fd, "%d %h", sq, pc);
            board[sq[5:0]] = piece_t'(pc);
          end
          if (num_tests < MAX_TESTS) begin
            positions[num_tests] = board;
            side_wtp[num_tests]  = (wtp != 0);
          end
          num_tests++;
        end
      end
      $fclose(fd);
      ok = (num_tests > 0) && (num_tests <= MAX_TESTS);
    end
  endtask

  // sop goes with square a1, and random idle cycles exercise gaps in valid
  task automatic load_position(input int t);
    for (int s = 0; s < NUM_SQUARES; s++) begin
      if (($random(seed) & 3) == 0) begin
        @(posedge clk);
        i_pos_valid <= 1'b0;
        i_pos_sop   <= 1'b0;
      end
      @(posedge clk);
      i_pos_valid <= 1'b1;
      i_pos_sop   <= (s == 0);
      i_pos_data  <= positions[t][s];
      i_wtp       <= side_wtp[t];
    end
    @(posedge clk);
    i_pos_valid <= 1'b0;
    i_pos_sop   <= 1'b0;
    i_pos_data  <= '0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
  endtask

  task automatic wait_for_eop();
    @(posedge clk);
    while (!o_uci_eop) begin
      @(posedge clk);
    end
  endtask

  initial begin
    bit ok;
    i_arst_n    = 1'b0;
    i_pos_valid = 1'b0;
    i_pos_data  = '0;
    i_pos_sop   = 1'b0;
    i_wtp       = 1'b0;
    i_start     = 1'b0;
    read_positions(ok);
    if (!ok) begin
      $display("golden file missing, empty or holding more than %0d tests", MAX_TESTS);
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      cycle_limit = RESET_CYCLES + num_tests * CYCLES_PER_TEST;
      repeat (RESET_CYCLES) @(posedge clk);
      i_arst_n <= 1'b1;
      @(posedge clk);
      for (int t = 0; t < num_tests; t++) begin
        load_position(t);
        pulse_start();
        wait_for_eop();
      end
      // give the checker time to close the last test
      repeat (2) @(posedge clk);
      $display("%0d of %0d tests checked, %0d failed, %0d errors",
               tests_done, num_tests, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0 && tests_done == num_tests) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

//--- bench/movegen_checker.sv
`timescale 1ns/1ps

module movegen_checker (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_uci_valid,
  input  movegen_pkg::uci_move_t i_uci_data,
  input  logic                   i_uci_sop,
  input  logic                   i_uci_eop,
  output int                     o_tests_done,
  output int                     o_tests_failed,
  output int                     o_error_count
);

  import movegen_pkg::*;

  // expected move lists of all tests, stored back to back in file order
  string     test_names [$];
  int        first_word [$];
  int        word_count [$];
  uci_move_t exp_words  [$];

  int cur_test     = 0;
  int seen         = 0;
  int test_errors  = 0;
  int tests_done   = 0;
  int tests_failed = 0;
  int error_count  = 0;

  assign o_tests_done   = tests_done;
  assign o_tests_failed = tests_failed;
  assign o_error_count  = error_count;

  // the checker reads the golden file on its own so it never depends on the driver
  initial begin
    int            fd;
    int            code;
    int            nsq;
    int            sq;
    int            pc;
    int            wtp;
    int            cnt;
    string         tok;
    string         name;
    uci_move_t     word;
    logic [1023:0] skip_line;
    cnt = 0;
    fd  = $fopen("bench/movegen_golden.txt", "r");
    if (fd == 0) begin
      $display("checker could not open bench/movegen_golden.txt");
      error_count++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          code = $fgets(skip_line, fd);
        end else if (tok == "test") begin
          // the position itself only matters to the driver
          code = $fscanf(fd, "%s %d %d", name, wtp, nsq);
          for (int k = 0; k < nsq; k++) begin
            code = $fscanf(fd, "%d %h", sq, pc);
          end
          test_names.push_back(name);
          first_word.push_back(exp_words.size());
          cnt = 0;
        end else if (tok == "end") begin
          word_count.push_back(cnt);
        end else begin
          code = $sscanf(tok, "%h", word);
          exp_words.push_back(word);
          cnt++;
        end
      end
      $fclose(fd);
    end
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    error_count++;
    test_errors++;
  endtask

  // sop belongs on the first move only, and every word must match in order
  task automatic check_move();
    uci_move_t expected;
    if (seen == 0 && !i_uci_sop) begin
      report_error($sformatf("test %s: first move came without sop", test_names[cur_test]));
    end
    if (seen > 0 && i_uci_sop) begin
      report_error($sformatf("test %s: sop on move %0d", test_names[cur_test], seen));
    end
    if (seen >= word_count[cur_test]) begin
      report_error($sformatf("test %s: extra move %05h beyond the %0d expected",
                             test_names[cur_test], i_uci_data, word_count[cur_test]));
    end else begin
      expected = exp_words[first_word[cur_test] + seen];
      if (i_uci_data !== expected) begin
        $display("MISMATCH test %s move %0d expected %05h actual %05h",
                 test_names[cur_test], seen, expected, i_uci_data);
        error_count++;
        test_errors++;
      end
    end
    seen++;
  endtask

  // eop closes the test, riding on the last move or alone for an empty list
  task automatic close_test();
    if (seen < word_count[cur_test]) begin
      report_error($sformatf("test %s: only %0d of %0d moves arrived before eop",
                             test_names[cur_test], seen, word_count[cur_test]));
    end else if (seen > 0 && !i_uci_valid) begin
      report_error($sformatf("test %s: eop did not come with the last move",
                             test_names[cur_test]));
    end
    if (test_errors == 0) begin
      $display("test %s passed with %0d moves", test_names[cur_test], seen);
    end else begin
      $display("test %s failed with %0d errors", test_names[cur_test], test_errors);
      tests_failed++;
    end
    tests_done++;
    cur_test++;
    seen        = 0;
    test_errors = 0;
  endtask

  // outputs come from flops, so the values seen at the edge are the settled ones
  always @(posedge clk) begin
    if (i_arst_n && (i_uci_valid || i_uci_sop || i_uci_eop)) begin
      if (cur_test >= test_names.size()) begin
        $display("DUT produced output after the last expected test had ended");
        error_count++;
      end else begin
        if (i_uci_valid) begin
          check_move();
        end else if (i_uci_sop) begin
          report_error($sformatf("test %s: sop came without a valid move", test_names[cur_test]));
        end
        if (i_uci_eop) begin
          close_test();
        end
      end
    end
  end

endmodule

//--- design/movegen_top.sv
`timescale 1ns/1ps

module movegen_top (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_pos_valid,
  input  movegen_pkg::piece_t    i_pos_data,
  input  logic                   i_pos_sop,
  input  logic                   i_wtp,
  input  logic                   i_start,
  output logic                   o_uci_valid,
  output movegen_pkg::uci_move_t o_uci_data,
  output logic                   o_uci_sop,
  output logic                   o_uci_eop
);

  import movegen_pkg::*;

  piece_t                 board [NUM_SQUARES];
  square_t                cur_sq;
  stack_entry_t           top;
  logic                   next_full;
  logic [NUM_SQUARES-1:0] targets;
  logic                   to_valid;
  square_t                to_sq;
  logic                   done;

  // the load bus feeds the board and the colour stacks in parallel
  board_squares board_squares_inst (
    .clk(clk), .i_arst_n(i_arst_n), .i_pos_valid(i_pos_valid), .i_pos_sop(i_pos_sop),
    .i_pos_data(i_pos_data), .o_cur_sq(cur_sq), .o_board(board)
  );

  piece_stacks piece_stacks_inst (
    .clk(clk), .i_arst_n(i_arst_n), .i_pos_valid(i_pos_valid), .i_pos_sop(i_pos_sop),
    .i_pos_data(i_pos_data), .i_cur_sq(cur_sq), .i_wtp(i_wtp), .i_start(i_start),
    .i_done(done), .o_top(top), .o_next_full(next_full)
  );

  // top piece to destination mask to one grant per cycle
  move_targets move_targets_inst (
    .i_top(top), .i_board(board), .i_wtp(i_wtp), .o_targets(targets)
  );

  target_arbiter target_arbiter_inst (
    .clk(clk), .i_arst_n(i_arst_n), .i_start(i_start), .i_targets(targets),
    .o_to_valid(to_valid), .o_to_sq(to_sq), .o_done(done)
  );

  move_emitter move_emitter_inst (
    .clk(clk), .i_arst_n(i_arst_n), .i_start(i_start), .i_top(top), .i_board(board),
    .i_to_valid(to_valid), .i_to_sq(to_sq), .i_done(done), .i_next_full(next_full),
    .o_uci_valid(o_uci_valid), .o_uci_data(o_uci_data), .o_uci_sop(o_uci_sop),
    .o_uci_eop(o_uci_eop)
  );

endmodule

//--- design/move_emitter.sv
`timescale 1ns/1ps

module move_emitter (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_start,
  input  movegen_pkg::stack_entry_t i_top,
  input  movegen_pkg::piece_t       i_board [movegen_pkg::NUM_SQUARES],
  input  logic                      i_to_valid,
  input  movegen_pkg::square_t      i_to_sq,
  input  logic                      i_done,
  input  logic                      i_next_full,
  output logic                      o_uci_valid,
  output movegen_pkg::uci_move_t    o_uci_data,
  output logic                      o_uci_sop,
  output logic                      o_uci_eop
);

  import movegen_pkg::*;

  uci_move_t move_word;
  uci_move_t buf_data_q;
  logic      buf_valid_q;
  logic      buf_sop_q;
  logic      first_sent_q;
  // high from start until the list is closed, since an idle empty stack raises done every cycle
  logic      active_q;
  logic      final_done;
  logic      emit;

  // the word for the current grant, takes comes straight from the board registers
  always_comb begin
    move_word           = '0;
    move_word.promote   = 2'd0;
    move_word.piece     = i_top.ptype;
    move_word.from_file = i_top.sq[2:0];
    move_word.from_rank = i_top.sq[5:3];
    move_word.takes     = i_board[i_to_sq][2:0];
    move_word.to_file   = i_to_sq[2:0];
    move_word.to_rank   = i_to_sq[5:3];
  end

  // the list ends when the last piece runs out of destinations
  assign final_done = active_q && i_done && !i_next_full;
  // the buffered move goes out once another grant or the end shows up
  assign emit       = i_to_valid || final_done;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      active_q     <= 1'b0;
      first_sent_q <= 1'b0;
      buf_valid_q  <= 1'b0;
      buf_sop_q    <= 1'b0;
      o_uci_valid  <= 1'b0;
      o_uci_sop    <= 1'b0;
      o_uci_eop    <= 1'b0;
    end else begin
      if (i_start) active_q <= 1'b1;
      else if (final_done) active_q <= 1'b0;
      // only the first grant of a run carries sop into the buffer
      if (i_to_valid) begin
        buf_sop_q    <= !first_sent_q;
        first_sent_q <= 1'b1;
      end
      if (final_done) first_sent_q <= 1'b0;
      // on the final done the buffer empties, so the next run begins clean
      if (emit) buf_valid_q <= i_to_valid;
      o_uci_valid <= buf_valid_q && emit;
      o_uci_sop   <= buf_valid_q && buf_sop_q && emit;
      // with no move in the buffer eop goes out alone
      o_uci_eop   <= final_done;
    end
  end

  always_ff @(posedge clk) begin
    if (i_to_valid) buf_data_q <= move_word;
    o_uci_data <= buf_data_q;
  end

endmodule

//--- design/target_arbiter.sv
`timescale 1ns/1ps

module target_arbiter (
  input  logic                                clk,
  input  logic                                i_arst_n,
  input  logic                                i_start,
  input  logic [movegen_pkg::NUM_SQUARES-1:0] i_targets,
  output logic                                o_to_valid,
  output movegen_pkg::square_t                o_to_sq,
  output logic                                o_done
);

  import movegen_pkg::*;

  // bit 64 is always requested, so it wins once the real targets run out
  logic [NUM_SQUARES:0] req;
  logic [NUM_SQUARES:0] masked;
  logic [NUM_SQUARES:0] grant;
  // one-hot pointer to the lowest square still allowed to win
  logic [NUM_SQUARES:0] base_q;

  assign req = {1'b1, i_targets};

  // drop everything below the base, then keep the lowest bit with the carry trick
  assign masked = req & ~(base_q - 1'b1);
  assign grant  = masked & (~masked + 1'b1);

  assign o_to_valid = |grant[NUM_SQUARES-1:0];
  assign o_done     = grant[NUM_SQUARES];

  // a one-hot grant lets the index be built by OR-ing
  always_comb begin
    o_to_sq = '0;
    for (int s = 0; s < NUM_SQUARES; s++) begin
      if (grant[s]) o_to_sq = o_to_sq | square_t'(s);
    end
  end

  // after a grant the base steps past it, so destinations come out in ascending order
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      base_q <= {{NUM_SQUARES{1'b0}}, 1'b1};
    end else if (i_start || o_done) begin
      base_q <= {{NUM_SQUARES{1'b0}}, 1'b1};
    end else if (o_to_valid) begin
      base_q <= {grant[NUM_SQUARES-1:0], 1'b0};
    end
  end

  // the base only moves upwards within one piece
  // a mask that changed under it could lose a destination below the base
  a_targets_stable : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (!i_start && !o_done) |=> $stable(i_targets)
  );

endmodule

//--- design/move_targets.sv
`timescale 1ns/1ps

module move_targets (
  input  movegen_pkg::stack_entry_t              i_top,
  input  movegen_pkg::piece_t                    i_board [movegen_pkg::NUM_SQUARES],
  input  logic                                   i_wtp,
  output logic [movegen_pkg::NUM_SQUARES-1:0]    o_targets
);

  import movegen_pkg::*;

  function automatic logic is_empty(piece_t p);
    return p[2:0] == PIECE_NONE;
  endfunction

  // an enemy is any occupied square whose colour differs from the mover's
  function automatic logic is_enemy(piece_t p, logic wtp);
    return !is_empty(p) && (p[3] != wtp);
  endfunction

  function automatic logic on_board(int r, int f);
    return (r >= 0) && (r < 8) && (f >= 0) && (f < 8);
  endfunction

  // all destinations of the top piece are raised at once
  // the stack only holds pieces of the side to move, so i_wtp gives the mover's colour
  always_comb begin
    int rank;
    int file;
    int dir;
    int tr;
    int tf;
    o_targets = '0;
    rank      = int'(i_top.sq[5:3]);
    file      = int'(i_top.sq[2:0]);
    // white pawns head up the board and black pawns head down
    dir       = i_wtp ? 1 : -1;
    tr        = 0;
    tf        = 0;

    if (i_top.full && i_top.ptype == PIECE_KNIGHT) begin
      // knights jump, so only the landing square is looked at
      for (int k = 0; k < 8; k++) begin
        tr = rank + KNIGHT_DR[k];
        tf = file + KNIGHT_DF[k];
        if (on_board(tr, tf)) begin
          if (is_empty(i_board[tr*8+tf]) || is_enemy(i_board[tr*8+tf], i_wtp)) begin
            o_targets[tr*8+tf] = 1'b1;
          end
        end
      end
    end else if (i_top.full && i_top.ptype == PIECE_PAWN) begin
      tr = rank + dir;
      if (tr >= 0 && tr < 8) begin
        // the single push needs an empty square, any piece in front blocks it
        if (is_empty(i_board[tr*8+file])) begin
          o_targets[tr*8+file] = 1'b1;
        end
        // diagonals are only legal as captures
        for (int df = -1; df <= 1; df += 2) begin
          tf = file + df;
          if (on_board(tr, tf)) begin
            if (is_enemy(i_board[tr*8+tf], i_wtp)) begin
              o_targets[tr*8+tf] = 1'b1;
            end
          end
        end
      end
    end
    // kings, queens, rooks and bishops raise nothing and are simply popped
  end

endmodule

//--- design/piece_stacks.sv
`timescale 1ns/1ps

module piece_stacks (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_pos_valid,
  input  logic                      i_pos_sop,
  input  movegen_pkg::piece_t       i_pos_data,
  input  movegen_pkg::square_t      i_cur_sq,
  input  logic                      i_wtp,
  input  logic                      i_start,
  input  logic                      i_done,
  output movegen_pkg::stack_entry_t o_top,
  output logic                      o_next_full
);

  import movegen_pkg::*;

  // slot 0 is the top of every stack
  stack_entry_t white_q [STACK_DEPTH];
  stack_entry_t black_q [STACK_DEPTH];
  stack_entry_t move_q  [STACK_DEPTH];
  stack_entry_t push_entry;
  logic         is_piece;
  logic         push_w;
  logic         push_b;
  logic         sop_start;

  // empty squares push nothing, occupied ones go to the stack of their colour
  assign is_piece   = i_pos_valid && (i_pos_data[2:0] != PIECE_NONE);
  assign push_w     = is_piece && i_pos_data[3];
  assign push_b     = is_piece && !i_pos_data[3];
  assign sop_start  = i_pos_valid && i_pos_sop;
  assign push_entry = '{full: 1'b1, ptype: i_pos_data[2:0], sq: i_cur_sq};

  // a push goes in at the top and moves the older entries down one slot
  // the later squares end up on top, so pieces come out from h8 towards a1
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int k = 0; k < STACK_DEPTH; k++) begin
        white_q[k] <= '0;
        black_q[k] <= '0;
      end
    end else if (sop_start) begin
      // a new position drops the old pieces and can still push square 0
      for (int k = 0; k < STACK_DEPTH; k++) begin
        white_q[k] <= '0;
        black_q[k] <= '0;
      end
      if (push_w) white_q[0] <= push_entry;
      if (push_b) black_q[0] <= push_entry;
    end else begin
      if (push_w) begin
        white_q[0] <= push_entry;
        for (int k = 1; k < STACK_DEPTH; k++) white_q[k] <= white_q[k-1];
      end
      if (push_b) begin
        black_q[0] <= push_entry;
        for (int k = 1; k < STACK_DEPTH; k++) black_q[k] <= black_q[k-1];
      end
    end
  end

  // the move stack takes a parallel copy of one colour stack and leaves that stack alone
  // every done from the arbiter moves the next piece up to the top
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int k = 0; k < STACK_DEPTH; k++) move_q[k] <= '0;
    end else if (i_start) begin
      for (int k = 0; k < STACK_DEPTH; k++) move_q[k] <= i_wtp ? white_q[k] : black_q[k];
    end else if (i_done) begin
      for (int k = 0; k < STACK_DEPTH - 1; k++) move_q[k] <= move_q[k+1];
      move_q[STACK_DEPTH-1] <= '0;
    end
  end

  assign o_top       = move_q[0];
  assign o_next_full = move_q[1].full;

  // a 17th piece of one colour would push the bottom entry out of its stack
  a_no_stack_overflow : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    !sop_start |-> !(push_w && white_q[STACK_DEPTH-1].full) &&
                   !(push_b && black_q[STACK_DEPTH-1].full)
  );

endmodule

//--- design/board_squares.sv
`timescale 1ns/1ps

module board_squares (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_pos_valid,
  input  logic                 i_pos_sop,
  input  movegen_pkg::piece_t  i_pos_data,
  output movegen_pkg::square_t o_cur_sq,
  output movegen_pkg::piece_t  o_board [movegen_pkg::NUM_SQUARES]
);

  import movegen_pkg::*;

  // the extra top bit flags that all 64 squares have been written
  logic [6:0] load_cnt;
  logic       sop_start;
  square_t    cur_sq;

  // sop only counts when it comes with a valid nibble
  assign sop_start = i_pos_valid && i_pos_sop;

  // the first nibble of a position always lands on a1, whatever the counter held
  assign cur_sq   = sop_start ? square_t'(0) : load_cnt[5:0];
  assign o_cur_sq = cur_sq;

  // the count moves on by one for every valid nibble and ignores gaps in valid
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      load_cnt <= '0;
    end else if (i_pos_valid) begin
      load_cnt <= {1'b0, cur_sq} + 7'd1;
    end
  end

  // each square keeps the last nibble written to it
  // the stacks see the same nibble on the same edge so they stay in step with this board
  always_ff @(posedge clk) begin
    if (i_pos_valid) begin
      o_board[cur_sq] <= i_pos_data;
    end
  end

  // once square 63 is written, only a new sop may bring more data
  // a 65th nibble would otherwise wrap back onto a1 without notice
  a_no_overrun : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (i_pos_valid && !i_pos_sop) |-> !load_cnt[6]
  );

endmodule

//--- design/movegen_pkg.sv
package movegen_pkg;

  // squares are numbered rank times eight plus file so a1 is 0 and h8 is 63
  localparam int NUM_SQUARES = 64;

  // each colour can hold at most sixteen pieces
  localparam int STACK_DEPTH = 16;

  // top bit is the colour with white set and the low three bits are the type
  typedef logic [3:0] piece_t;
  typedef logic [5:0] square_t;

  // type codes follow none, king, queen, rook, bishop, knight, pawn
  localparam logic [2:0] PIECE_NONE   = 3'd0;
  localparam logic [2:0] PIECE_KNIGHT = 3'd5;
  localparam logic [2:0] PIECE_PAWN   = 3'd6;

  // the eight knight jumps as rank and file offsets, listed as matching pairs
  localparam int KNIGHT_DR [8] = '{2, 2, 1, 1, -1, -1, -2, -2};
  localparam int KNIGHT_DF [8] = '{1, -1, 2, -2, 2, -2, 1, -1};

  // one slot of a piece stack, an empty slot has full low
  typedef struct packed {
    logic       full;
    logic [2:0] ptype;
    square_t    sq;
  } stack_entry_t;

  // 20-bit UCI move word, promote sits at the top
  typedef struct packed {
    logic [1:0] promote;
    logic [2:0] piece;
    logic [2:0] from_file;
    logic [2:0] from_rank;
    logic [2:0] takes;
    logic [2:0] to_file;
    logic [2:0] to_rank;
  } uci_move_t;

endpackage
